// File: Makefile
# Verilator build and run of the token robot testbench
VERILATOR ?= verilator
TOP       ?= tb_token_robot
LOG       ?= sim.log
SEED      ?= 54
BUILD     ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f all.f
	@$(BUILD)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1; \
	status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

// File: all.f
robot_pkg.sv
frame_if.sv
frame_assembler.sv
frame_queue.sv
command_sequencer.sv
serial_tx.sv
servo_pwm.sv
token_robot_top.sv
token_robot_properties.sv
tb_token_robot.sv

// File: command_sequencer.sv
// command_sequencer: FSM that runs queued frames, sends replies and holds
// the maintenance positions of the servos
`timescale 1ns/1ps

module command_sequencer (
	input  logic                  clk50m,
	input  logic                  reset,
	frame_if.receiver             frame,
	output logic                  take,
	output logic                  tx_start,
	output robot_pkg::cmd_byte_t  tx_data,
	input  logic                  tx_busy,
	output robot_pkg::servo_pos_t positions [robot_pkg::NUM_SERVOS]
);

	typedef enum logic [2:0] {
		s_announce,
		s_idle,
		s_decode,
		s_send_first,
		s_send_second,
		s_wait_tx
	} state_t;

	state_t               state;
	logic                 second_pending;
	logic                 seen_busy;
	robot_pkg::cmd_byte_t verb_q;
	robot_pkg::cmd_byte_t arg1_q;
	robot_pkg::cmd_byte_t reply_q;

	// frame leaves the queue on the same clock it is latched
	assign take = (state == s_idle) && frame.valid;

	always_ff @(posedge clk50m or negedge reset) begin
		if (!reset) begin
			state <= s_announce;
			tx_start <= 1'b0;
			second_pending <= 1'b0;
			seen_busy <= 1'b0;
			for (int i = 0; i < robot_pkg::NUM_SERVOS; i++) begin
				positions[i] <= '0;
			end
		end else begin
			tx_start <= 1'b0;
			case (state)
				s_announce: begin
					if (!tx_busy) begin
						tx_start <= 1'b1;
						second_pending <= 1'b0;
						state <= s_wait_tx;
					end
				end
				s_idle: begin
					if (frame.valid) begin
						state <= s_decode;
						// servos move straight from the queue output
						if (frame.verb == robot_pkg::VERB_MTNE) begin
							for (int i = 0; i < robot_pkg::NUM_SERVOS; i++) begin
								if (frame.arg1 == robot_pkg::MTNE_CLEAR) begin
									positions[i] <= '0;
								end else if (frame.arg1 ==
										robot_pkg::cmd_byte_t'(robot_pkg::MTNE_SERVO1 + i)) begin
									positions[i] <= frame.arg2;
								end
							end
						end
					end
				end
				s_decode: begin
					case (verb_q)
						robot_pkg::VERB_NOP: state <= s_idle;
						robot_pkg::VERB_RESTART: state <= s_announce;
						robot_pkg::VERB_PING: begin
							second_pending <= 1'b0;
							state <= s_send_first;
						end
						robot_pkg::VERB_MTNE: begin
							case (arg1_q)
								robot_pkg::MTNE_CLEAR,
								robot_pkg::MTNE_SERVO1,
								robot_pkg::MTNE_SERVO2,
								robot_pkg::MTNE_SERVO3: begin
									second_pending <= 1'b1;
									state <= s_send_first;
								end
								// unknown sub-command restarts
								default: state <= s_announce;
							endcase
						end
						default: state <= s_idle;
					endcase
				end
				s_send_first: begin
					if (!tx_busy) begin
						tx_start <= 1'b1;
						state <= s_wait_tx;
					end
				end
				s_send_second: begin
					if (!tx_busy) begin
						tx_start <= 1'b1;
						second_pending <= 1'b0;
						state <= s_wait_tx;
					end
				end
				default: begin
					// busy has to rise and fall again before the next byte
					if (tx_busy) begin
						seen_busy <= 1'b1;
					end else if (seen_busy) begin
						seen_busy <= 1'b0;
						state <= second_pending ? s_send_second : s_idle;
					end
				end
			endcase
		end
	end

	// latched frame fields and reply bytes
	always_ff @(posedge clk50m) begin
		if (take) begin
			verb_q <= frame.verb;
			arg1_q <= frame.arg1;
		end
		if (state == s_decode) begin
			reply_q <= (verb_q == robot_pkg::VERB_PING) ? robot_pkg::REPLY_PONG
				: robot_pkg::REPLY_ACK;
		end
		case (state)
			s_announce: tx_data <= robot_pkg::REPLY_INIT;
			s_send_first: tx_data <= reply_q;
			// verb echo
			s_send_second: tx_data <= verb_q;
			default: tx_data <= tx_data;
		endcase
	end

endmodule

// File: frame_assembler.sv
// frame_assembler: gathers four strobed command bytes into one frame
// verb, arg1, arg2, arg3 in arrival order, then a one-cycle valid pulse
`timescale 1ns/1ps

module frame_assembler (
	input  logic                 clk50m,
	input  logic                 reset,
	input  robot_pkg::cmd_byte_t data,
	input  logic                 data_trig,
	frame_if.sender              frame
);

	logic [1:0] byte_cnt;

	// byte position and the push pulse
	always_ff @(posedge clk50m or negedge reset) begin
		if (!reset) begin
			byte_cnt <= 2'd0;
			frame.valid <= 1'b0;
		end else begin
			frame.valid <= data_trig && (byte_cnt == 2'd3);
			if (data_trig) begin
				// wraps to zero only after arg3
				byte_cnt <= byte_cnt + 2'd1;
			end
		end
	end

	// frame bytes
	always_ff @(posedge clk50m) begin
		if (data_trig) begin
			case (byte_cnt)
				2'd0: frame.verb <= data;
				2'd1: frame.arg1 <= data;
				2'd2: frame.arg2 <= data;
				default: frame.arg3 <= data;
			endcase
		end
	end

endmodule

// File: frame_if.sv
// frame_if: one four-byte command frame with its valid flag
`timescale 1ns/1ps

interface frame_if;

	robot_pkg::cmd_byte_t verb;
	robot_pkg::cmd_byte_t arg1;
	robot_pkg::cmd_byte_t arg2;
	robot_pkg::cmd_byte_t arg3;
	// push pulse on the assembler side, not-empty level on the queue side
	logic valid;

	modport sender (output verb, arg1, arg2, arg3, valid);
	modport receiver (input verb, arg1, arg2, arg3, valid);

endinterface

// File: frame_queue.sv
// frame_queue: circular FIFO of command frames between assembler and sequencer
// new frames are dropped while full, the host has no stall
`timescale 1ns/1ps

module frame_queue #(
	parameter int frame_depth = 4
) (
	input  logic      clk50m,
	input  logic      reset,
	frame_if.receiver push_side,
	frame_if.sender   pop_side,
	input  logic      take
);

	localparam int ptr_w = (frame_depth > 1) ? $clog2(frame_depth) : 1;
	localparam int cnt_w = $clog2(frame_depth + 1);

	// one entry holds verb, arg1, arg2, arg3
	robot_pkg::cmd_byte_t mem [frame_depth][4];

	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;
	logic             do_push;
	logic             do_pop;

	assign do_push = push_side.valid && (count != cnt_w'(frame_depth));
	assign do_pop  = take && (count != '0);

	always_ff @(posedge clk50m or negedge reset) begin
		if (!reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == ptr_w'(frame_depth - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == ptr_w'(frame_depth - 1)) ? '0 : rd_ptr + 1'b1;
			end
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clk50m) begin
		if (do_push) begin
			mem[wr_ptr][0] <= push_side.verb;
			mem[wr_ptr][1] <= push_side.arg1;
			mem[wr_ptr][2] <= push_side.arg2;
			mem[wr_ptr][3] <= push_side.arg3;
		end
	end

	// oldest frame is always on show
	assign pop_side.verb  = mem[rd_ptr][0];
	assign pop_side.arg1  = mem[rd_ptr][1];
	assign pop_side.arg2  = mem[rd_ptr][2];
	assign pop_side.arg3  = mem[rd_ptr][3];
	assign pop_side.valid = (count != '0);

endmodule

// File: robot_pkg.sv
// robot_pkg: shared types and command codes for the token robot controller
// byte widths, servo positions, verbs, maintenance sub-codes and reply bytes
package robot_pkg;

	// one command or reply byte on the serial link
	typedef logic [7:0] cmd_byte_t;

	// maintenance position of a single servo
	typedef logic [7:0] servo_pos_t;

	localparam int NUM_SERVOS = 3;

	// verbs, first byte of a frame
	localparam cmd_byte_t VERB_NOP     = 8'd0;
	localparam cmd_byte_t VERB_RESTART = 8'd1;
	localparam cmd_byte_t VERB_PING    = 8'd2;
	localparam cmd_byte_t VERB_MTNE    = 8'd3;

	// maintenance sub-commands, carried in arg1
	localparam cmd_byte_t MTNE_CLEAR  = 8'd0;
	localparam cmd_byte_t MTNE_SERVO1 = 8'd1;
	localparam cmd_byte_t MTNE_SERVO2 = 8'd2;
	localparam cmd_byte_t MTNE_SERVO3 = 8'd3;

	// reply bytes sent back to the host
	localparam cmd_byte_t REPLY_INIT = 8'd1;
	localparam cmd_byte_t REPLY_ACK  = 8'd4;
	localparam cmd_byte_t REPLY_PONG = 8'd5;

endpackage

// File: serial_tx.sv
// serial_tx: 8N1 UART transmitter, LSB first, busy for the whole frame
`timescale 1ns/1ps

module serial_tx #(
	parameter int clks_per_bit = 434
) (
	input  logic                 clk50m,
	input  logic                 reset,
	input  logic                 start,
	input  robot_pkg::cmd_byte_t data,
	output logic                 serial_out,
	output logic                 busy
);

	localparam int cnt_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;

	logic [cnt_w-1:0] clk_cnt;
	logic [3:0]       bit_cnt;
	// stop, data, start; bit 0 is on the line
	logic [9:0]       shift_q;

	always_ff @(posedge clk50m or negedge reset) begin
		if (!reset) begin
			clk_cnt <= '0;
			bit_cnt <= 4'd0;
			shift_q <= '1;
			busy <= 1'b0;
		end else if (!busy) begin
			if (start) begin
				shift_q <= {1'b1, data, 1'b0};
				clk_cnt <= '0;
				bit_cnt <= 4'd0;
				busy <= 1'b1;
			end
		end else if (clk_cnt == cnt_w'(clks_per_bit - 1)) begin
			clk_cnt <= '0;
			// ones fill in behind, so the line idles high
			shift_q <= {1'b1, shift_q[9:1]};
			if (bit_cnt == 4'd9) begin
				busy <= 1'b0;
			end else begin
				bit_cnt <= bit_cnt + 4'd1;
			end
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

	assign serial_out = shift_q[0];

endmodule

// File: servo_pwm.sv
// servo_pwm: periodic servo pulse, width set by the position at period start
`timescale 1ns/1ps

module servo_pwm #(
	parameter int pwm_period = 1000000,
	parameter int pulse_base = 50000,
	parameter int pulse_step = 196
) (
	input  logic                  clk50m,
	input  logic                  reset,
	input  robot_pkg::servo_pos_t position,
	output logic                  pwm
);

	// widest pulse at position 255
	localparam int max_width = pulse_base + 255 * pulse_step;
	localparam int cnt_w = $clog2(((pwm_period > max_width) ? pwm_period : max_width) + 1);

	logic [cnt_w-1:0] period_cnt;
	logic [cnt_w-1:0] width_q;

	always_ff @(posedge clk50m or negedge reset) begin
		if (!reset) begin
			period_cnt <= '0;
			width_q <= '0;
		end else if (period_cnt == cnt_w'(pwm_period - 1)) begin
			period_cnt <= '0;
			// new width holds for the whole next period
			width_q <= cnt_w'(pulse_base) + cnt_w'(position) * cnt_w'(pulse_step);
		end else begin
			period_cnt <= period_cnt + 1'b1;
		end
	end

	assign pwm = (period_cnt < width_q);

endmodule

// File: tb_token_robot.sv
// tb_token_robot: table-driven testbench for the token robot controller
// decodes the serial replies and measures the servo pulse widths
`timescale 1ns/1ps

module tb_token_robot;

	localparam int CLKS_PER_BIT = 8;
	localparam int PWM_PERIOD = 600;
	localparam int PULSE_BASE = 20;
	localparam int PULSE_STEP = 2;
	localparam int NUM_TESTS = 12;
	localparam int BYTE_TIMEOUT = 2000;
	localparam int QUIET_CYCLES = 300;
	localparam int WATCHDOG_CYCLES = 100000;

	logic                             clk50m;
	logic                             reset;
	robot_pkg::cmd_byte_t             data;
	logic                             data_trig;
	logic                             serial_return;
	logic                             txbusy;
	logic [robot_pkg::NUM_SERVOS-1:0] pwm;

	// stimulus and expected values, one row per test
	string                 test_name [NUM_TESTS];
	robot_pkg::cmd_byte_t  frame_tab [NUM_TESTS][4];
	int                    copies_tab [NUM_TESTS];
	int                    nrep_tab [NUM_TESTS];
	robot_pkg::cmd_byte_t  reply_tab [NUM_TESTS][2];
	robot_pkg::servo_pos_t pos_tab [NUM_TESTS][robot_pkg::NUM_SERVOS];

	robot_pkg::servo_pos_t exp_pos [robot_pkg::NUM_SERVOS];
	int                    high_cnt [robot_pkg::NUM_SERVOS];
	int                    errors;
	int                    test_errors;
	int                    tests_run;
	int                    tests_failed;

	token_robot_top #(
		.clks_per_bit(CLKS_PER_BIT),
		.frame_depth(4),
		.pwm_period(PWM_PERIOD),
		.pulse_base(PULSE_BASE),
		.pulse_step(PULSE_STEP)
	) token_robot_top_inst (
		.clk50m(clk50m),
		.reset(reset),
		.data(data),
		.data_trig(data_trig),
		.serial_return(serial_return),
		.txbusy(txbusy),
		.pwm(pwm)
	);

	initial clk50m = 1'b0;
	always #10 clk50m = ~clk50m;

	task automatic note_failure(input string msg);
		$display("%s", msg);
		test_errors++;
	endtask

	task automatic check_byte(input string name, input robot_pkg::cmd_byte_t exp,
			input robot_pkg::cmd_byte_t act);
		if (act !== exp) begin
			$display("FAILED %s: expected 0x%02h, got 0x%02h", name, exp, act);
			test_errors++;
		end
	endtask

	task automatic check_pos(input string name, input robot_pkg::servo_pos_t exp,
			input robot_pkg::servo_pos_t act);
		if (act !== exp) begin
			$display("FAILED %s: expected position %0d, got %0d", name, exp, act);
			test_errors++;
		end
	endtask

	task automatic add_test(input int idx, input string name, input int v, input int a1,
			input int a2, input int a3, input int copies, input int nrep, input int r0,
			input int r1, input int p0, input int p1, input int p2);
		test_name[idx] = name;
		frame_tab[idx][0] = robot_pkg::cmd_byte_t'(v);
		frame_tab[idx][1] = robot_pkg::cmd_byte_t'(a1);
		frame_tab[idx][2] = robot_pkg::cmd_byte_t'(a2);
		frame_tab[idx][3] = robot_pkg::cmd_byte_t'(a3);
		copies_tab[idx] = copies;
		nrep_tab[idx] = nrep;
		reply_tab[idx][0] = robot_pkg::cmd_byte_t'(r0);
		reply_tab[idx][1] = robot_pkg::cmd_byte_t'(r1);
		pos_tab[idx][0] = robot_pkg::servo_pos_t'(p0);
		pos_tab[idx][1] = robot_pkg::servo_pos_t'(p1);
		pos_tab[idx][2] = robot_pkg::servo_pos_t'(p2);
	endtask

	task automatic fill_table();
		int a;
		int b;
		int c;
		int d;
		a = int'($urandom_range(255, 1));
		b = int'($urandom_range(255, 1));
		c = int'($urandom_range(255, 1));
		d = int'($urandom_range(255, 1));
		// verb, arg1..3, copies, replies, reply bytes, servo positions after
		add_test(0, "ping", 2, 0, 0, 0, 1, 1, 5, 0, 0, 0, 0);
		add_test(1, "restart", 1, 0, 0, 0, 1, 1, 1, 0, 0, 0, 0);
		add_test(2, "set_servo1", 3, 1, a, 0, 1, 2, 4, 3, a, 0, 0);
		add_test(3, "set_servo2", 3, 2, b, 0, 1, 2, 4, 3, a, b, 0);
		add_test(4, "set_servo3", 3, 3, c, 0, 1, 2, 4, 3, a, b, c);
		add_test(5, "mtne_clear", 3, 0, 8'h55, 0, 1, 2, 4, 3, 0, 0, 0);
		add_test(6, "verb_nop", 0, 1, 2, 3, 1, 0, 0, 0, 0, 0, 0);
		add_test(7, "unknown_verb", 8'h2a, 1, 2, 3, 1, 0, 0, 0, 0, 0, 0);
		add_test(8, "ping_after_silent", 2, 0, 0, 0, 1, 1, 5, 0, 0, 0, 0);
		add_test(9, "set_servo2_again", 3, 2, d, 0, 1, 2, 4, 3, 0, d, 0);
		add_test(10, "mtne_bad_sub", 3, 9, 8'h10, 0, 1, 1, 1, 0, 0, d, 0);
		// faster than the replies can leave
		add_test(11, "ping_burst", 2, 0, 0, 0, 3, 1, 5, 0, 0, d, 0);
	endtask

	task automatic send_frames(input int t);
		for (int c = 0; c < copies_tab[t]; c++) begin
			for (int k = 0; k < 4; k++) begin
				@(posedge clk50m);
				data <= frame_tab[t][k];
				data_trig <= 1'b1;
			end
		end
		@(posedge clk50m);
		data_trig <= 1'b0;
	endtask

	// status 0 ok, 1 no start bit, 2 framing error
	task automatic recv_byte(output robot_pkg::cmd_byte_t b, output int status);
		int wait_cnt;
		b = '0;
		status = 1;
		wait_cnt = 0;
		@(negedge clk50m);
		while (serial_return !== 1'b0 && wait_cnt < BYTE_TIMEOUT) begin
			@(negedge clk50m);
			wait_cnt++;
		end
		if (serial_return === 1'b0) begin
			status = 2;
			// middle of the start bit
			repeat (CLKS_PER_BIT / 2) @(negedge clk50m);
			if (serial_return === 1'b0) begin
				for (int i = 0; i < 8; i++) begin
					repeat (CLKS_PER_BIT) @(negedge clk50m);
					b[i] = serial_return;
				end
				repeat (CLKS_PER_BIT) @(negedge clk50m);
				if (serial_return === 1'b1) begin
					status = 0;
				end
			end
		end
	endtask

	task automatic wait_line_quiet(output bit quiet);
		int wait_cnt;
		wait_cnt = 0;
		// rest of the last stop bit
		while (txbusy !== 1'b0 && wait_cnt < BYTE_TIMEOUT) begin
			@(negedge clk50m);
			wait_cnt++;
		end
		quiet = (txbusy === 1'b0);
		for (int i = 0; i < QUIET_CYCLES && quiet; i++) begin
			@(negedge clk50m);
			if (serial_return !== 1'b1 || txbusy !== 1'b0) begin
				quiet = 1'b0;
			end
		end
	endtask

	task automatic collect_replies(input int t);
		int total;
		int status;
		bit alive;
		bit quiet;
		robot_pkg::cmd_byte_t got;
		total = copies_tab[t] * nrep_tab[t];
		alive = 1'b1;
		for (int k = 0; k < total && alive; k++) begin
			recv_byte(got, status);
			if (status == 1) begin
				note_failure($sformatf("%s: reply %0d of %0d never arrived within %0d cycles",
					test_name[t], k + 1, total, BYTE_TIMEOUT));
				alive = 1'b0;
			end else if (status == 2) begin
				note_failure($sformatf("%s: reply %0d has a broken start or stop bit",
					test_name[t], k + 1));
				alive = 1'b0;
			end else begin
				check_byte($sformatf("%s reply %0d", test_name[t], k + 1),
					reply_tab[t][k % nrep_tab[t]], got);
			end
		end
		if (alive) begin
			wait_line_quiet(quiet);
			if (!quiet) begin
				note_failure($sformatf("%s: serial line active after the expected replies",
					test_name[t]));
			end
		end
	endtask

	// one period, aligned to the common period start
	task automatic measure_pwm(output bit ok);
		int cnt;
		logic prev;
		cnt = 0;
		@(negedge clk50m);
		prev = pwm[0];
		@(negedge clk50m);
		while (!(prev === 1'b0 && pwm[0] === 1'b1) && cnt < 2 * PWM_PERIOD) begin
			prev = pwm[0];
			@(negedge clk50m);
			cnt++;
		end
		ok = (prev === 1'b0 && pwm[0] === 1'b1);
		for (int s = 0; s < robot_pkg::NUM_SERVOS; s++) begin
			high_cnt[s] = 0;
		end
		for (int c = 0; c < PWM_PERIOD && ok; c++) begin
			for (int s = 0; s < robot_pkg::NUM_SERVOS; s++) begin
				if (pwm[s] === 1'b1) begin
					high_cnt[s]++;
				end
			end
			@(negedge clk50m);
		end
	endtask

	task automatic check_servos(input string name);
		bit ok;
		int span;
		measure_pwm(ok);
		if (!ok) begin
			note_failure($sformatf("%s: no pwm period start seen within %0d cycles",
				name, 2 * PWM_PERIOD));
		end else begin
			for (int s = 0; s < robot_pkg::NUM_SERVOS; s++) begin
				span = high_cnt[s] - PULSE_BASE;
				if (span < 0 || span % PULSE_STEP != 0 || span / PULSE_STEP > 255) begin
					note_failure($sformatf("%s: servo %0d pulse of %0d cycles fits no position",
						name, s + 1, high_cnt[s]));
				end else begin
					check_pos($sformatf("%s servo %0d", name, s + 1), exp_pos[s],
						robot_pkg::servo_pos_t'(span / PULSE_STEP));
				end
			end
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		errors += test_errors;
		if (test_errors == 0) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d check(s) failed", name, test_errors);
		end
	endtask

	initial begin
		robot_pkg::cmd_byte_t got;
		int status;
		bit quiet;
		void'($urandom(54));
		data = '0;
		data_trig = 1'b0;
		reset = 1'b0;
		errors = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		fill_table();
		repeat (3) @(posedge clk50m);
		reset <= 1'b1;

		// announcement after reset
		for (int s = 0; s < robot_pkg::NUM_SERVOS; s++) begin
			exp_pos[s] = '0;
		end
		recv_byte(got, status);
		if (status != 0) begin
			note_failure("reset: no clean init byte after reset");
		end else begin
			check_byte("reset reply", robot_pkg::REPLY_INIT, got);
			wait_line_quiet(quiet);
			if (!quiet) begin
				note_failure("reset: more than one byte sent after reset");
			end
		end
		check_servos("reset");
		finish_test("reset");

		for (int t = 0; t < NUM_TESTS; t++) begin
			test_errors = 0;
			for (int s = 0; s < robot_pkg::NUM_SERVOS; s++) begin
				exp_pos[s] = pos_tab[t][s];
			end
			fork
				send_frames(t);
				collect_replies(t);
			join
			check_servos(test_name[t]);
			finish_test(test_name[t]);
		end

		$display("%0d tests run, %0d passed, %0d failed, %0d checks failed",
			tests_run, tests_run - tests_failed, tests_failed, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	// overall limit on the run
	initial begin
		for (int c = 0; c < WATCHDOG_CYCLES; c++) begin
			@(posedge clk50m);
		end
		$display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// File: token_robot_properties.sv
// token_robot_properties: checks on the reply line, the queue take and the UART start
`timescale 1ns/1ps

module token_robot_properties (
	input logic clk50m,
	input logic reset,
	input logic serial_return,
	input logic txbusy,
	input logic take,
	input logic queue_valid,
	input logic tx_start
);

	// line idles high between frames
	a_line_idle: assert property (@(posedge clk50m) disable iff (!reset)
		!txbusy |-> serial_return)
		else $error("serial_return low while the transmitter is idle");

	// one take per frame, only from a non-empty queue
	a_take_valid: assert property (@(posedge clk50m) disable iff (!reset)
		take |=> (!take && $past(queue_valid)))
		else $error("take held for more than one cycle or taken from an empty queue");

	// a new byte only starts on an idle transmitter
	a_start_idle: assert property (@(posedge clk50m) disable iff (!reset)
		$rose(tx_start) |-> !txbusy)
		else $error("tx_start raised while the transmitter is busy");

endmodule

bind token_robot_top token_robot_properties token_robot_properties_inst (
	.clk50m(clk50m),
	.reset(reset),
	.serial_return(serial_return),
	.txbusy(txbusy),
	.take(take),
	.queue_valid(pop_link.valid),
	.tx_start(tx_start)
);

// File: token_robot_top.sv
// token_robot_top: serial command controller for the token robot
// frame assembly, frame queue, sequencer, reply UART and servo PWM
`timescale 1ns/1ps

module token_robot_top #(
	parameter int clks_per_bit = 434,
	parameter int frame_depth  = 4,
	parameter int pwm_period   = 1000000,
	parameter int pulse_base   = 50000,
	parameter int pulse_step   = 196
) (
	input  logic                              clk50m,
	input  logic                              reset,
	input  robot_pkg::cmd_byte_t              data,
	input  logic                              data_trig,
	output logic                              serial_return,
	output logic                              txbusy,
	output logic [robot_pkg::NUM_SERVOS-1:0]  pwm
);

	frame_if push_link ();
	frame_if pop_link ();

	logic                  take;
	logic                  tx_start;
	robot_pkg::cmd_byte_t  tx_data;
	robot_pkg::servo_pos_t positions [robot_pkg::NUM_SERVOS];

	frame_assembler frame_assembler_inst (
		.clk50m(clk50m),
		.reset(reset),
		.data(data),
		.data_trig(data_trig),
		.frame(push_link.sender)
	);

	frame_queue #(.frame_depth(frame_depth)) frame_queue_inst (
		.clk50m(clk50m),
		.reset(reset),
		.push_side(push_link.receiver),
		.pop_side(pop_link.sender),
		.take(take)
	);

	command_sequencer command_sequencer_inst (
		.clk50m(clk50m),
		.reset(reset),
		.frame(pop_link.receiver),
		.take(take),
		.tx_start(tx_start),
		.tx_data(tx_data),
		.tx_busy(txbusy),
		.positions(positions)
	);

	serial_tx #(.clks_per_bit(clks_per_bit)) serial_tx_inst (
		.clk50m(clk50m),
		.reset(reset),
		.start(tx_start),
		.data(tx_data),
		.serial_out(serial_return),
		.busy(txbusy)
	);

	// one pwm output per maintenance servo
	for (genvar i = 0; i < robot_pkg::NUM_SERVOS; i++) begin : g_servo
		servo_pwm #(
			.pwm_period(pwm_period),
			.pulse_base(pulse_base),
			.pulse_step(pulse_step)
		) servo_pwm_inst (
			.clk50m(clk50m),
			.reset(reset),
			.position(positions[i]),
			.pwm(pwm[i])
		);
	end

endmodule
